// ==== Makefile ====
# Verilator build and run of the SATA phy testbench

VERILATOR ?= verilator
TOP       ?= tb_sata_phy
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(wildcard verilog/*.sv verilog/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported failures"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_sata_phy.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "sata_defs.svh"

module tb_sata_phy
  import sata_prim_pkg::*, sata_link_pkg::*;
();

  localparam int          WAIT_LIMIT = 4 * `SATA_OOB_TIMEOUT;
  localparam logic [31:0] PRIM_ALIGN = `SATA_PRIM_ALIGN;
  localparam logic [31:0] PRIM_SYNC  = `SATA_PRIM_SYNC;
  localparam logic [31:0] PRIM_D10_2 = `SATA_PRIM_D10_2;

  logic        clk = 1'b0;
  logic        rst;
  logic        platform_ready;
  logic        phy_error;
  logic        platform_error;
  logic        linkup;
  logic        phy_ready;
  oob_state_e  oob_state;
  sata_dword_u tx_dout;
  logic        tx_is_k;
  logic        tx_comm_reset;
  logic        tx_comm_wake;
  logic        tx_elec_idle;
  logic        tx_oob_complete;
  sata_dword_u rx_din;
  logic [3:0]  rx_is_k;
  logic        rx_elec_idle;
  logic        rx_byte_is_aligned;
  logic        comm_init_detect;
  logic        comm_wake_detect;
  sata_dword_u in_data;
  logic        in_valid;
  logic        in_ready;

  int          error_count = 0;
  int          checks_run = 0;
  int          test_errors = 0;
  int          stall_cycles = 0;
  string       test_name;
  sata_dword_u exp_q[$];
  sata_dword_u rx_q[$];

  sata_phy_top uut (
    .clk                (clk),
    .rst                (rst),
    .platform_ready     (platform_ready),
    .phy_error          (phy_error),
    .platform_error     (platform_error),
    .linkup             (linkup),
    .phy_ready          (phy_ready),
    .oob_state          (oob_state),
    .tx_dout            (tx_dout),
    .tx_is_k            (tx_is_k),
    .tx_comm_reset      (tx_comm_reset),
    .tx_comm_wake       (tx_comm_wake),
    .tx_elec_idle       (tx_elec_idle),
    .tx_oob_complete    (tx_oob_complete),
    .rx_din             (rx_din),
    .rx_is_k            (rx_is_k),
    .rx_elec_idle       (rx_elec_idle),
    .rx_byte_is_aligned (rx_byte_is_aligned),
    .comm_init_detect   (comm_init_detect),
    .comm_wake_detect   (comm_wake_detect),
    .in_data            (in_data),
    .in_valid           (in_valid),
    .in_ready           (in_ready)
  );

  always #10 clk = ~clk;

  task automatic record_error();
    error_count++;
    test_errors++;
  endtask

  task automatic check_dword(input string name, input sata_dword_u got, input sata_dword_u exp);
    checks_run++;
    if (got.data !== exp.data) begin
      $display("[FAIL] %s got %h expected %h", name, got.data, exp.data);
      record_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks_run++;
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      record_error();
    end
  endtask

  task automatic check_state(input string name, input oob_state_e got, input oob_state_e exp);
    checks_run++;
    if (got !== exp) begin
      $display("[FAIL] %s got %h (%s) expected %h (%s)", name, got, got.name(), exp, exp.name());
      record_error();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks_run++;
    if (got != exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      record_error();
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    $display("Test %s finished with %0d errors", test_name, test_errors);
  endtask

  // Payload leaves with tx_is_k low
  // Idle READY cycles must carry SYNC
  always @(negedge clk) begin
    if (!rst && linkup && !tx_is_k) rx_q.push_back(tx_dout);
    if (!rst && linkup && phy_ready && tx_is_k) check_dword("tx_dout idle", tx_dout, PRIM_SYNC);
    if (!rst && in_valid && !in_ready) stall_cycles++;
  end

  task automatic wait_state(input oob_state_e target);
    int waited;
    waited = 0;
    @(negedge clk);
    while (oob_state != target && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (oob_state != target) begin
      $display("Timeout waiting for OOB state %s", target.name());
      record_error();
    end
  endtask

  task automatic wait_phy_ready(input logic level);
    int waited;
    waited = 0;
    @(negedge clk);
    while (phy_ready !== level && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (phy_ready !== level) begin
      $display("Timeout waiting for phy_ready to become %0d", level);
      record_error();
    end
  endtask

  // Transfer happens on the edge after in_ready is seen high
  task automatic send_word(input sata_dword_u w);
    int waited;
    waited = 0;
    @(posedge clk);
    in_data  <= w;
    in_valid <= 1'b1;
    @(negedge clk);
    while (!in_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ready) begin
      $display("Timeout waiting for in_ready");
      record_error();
    end else begin
      exp_q.push_back(w);
    end
  endtask

  task automatic send_words(input int count);
    sata_dword_u w;
    for (int i = 0; i < count; i++) begin
      w.data = $urandom;
      send_word(w);
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (rx_q.size() < exp_q.size() && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (rx_q.size() < exp_q.size()) begin
      $display("Timeout waiting for payload words on tx_dout");
      record_error();
    end
  endtask

  task automatic compare_payload();
    check_count("payload word count", rx_q.size(), exp_q.size());
    for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
      check_dword($sformatf("tx_dout word %0d", i), rx_q[i], exp_q[i]);
    end
    exp_q.delete();
    rx_q.delete();
  endtask

  // One-cycle pulse on {comm_wake_detect, comm_init_detect, tx_oob_complete}
  task automatic pulse_far_end(input logic [2:0] mask);
    @(posedge clk);
    {comm_wake_detect, comm_init_detect, tx_oob_complete} <= mask;
    @(posedge clk);
    {comm_wake_detect, comm_init_detect, tx_oob_complete} <= 3'b000;
  endtask

  // Far-end device answering the host OOB sequence up to the first linkup cycle
  task automatic far_end_bring_up();
    @(posedge clk);
    rx_din.data        <= PRIM_D10_2;
    rx_is_k            <= 4'h0;
    rx_byte_is_aligned <= 1'b0;
    wait_state(SEND_COMRESET);
    check_bit("tx_comm_reset", tx_comm_reset, 1'b1);
    check_bit("tx_comm_wake", tx_comm_wake, 1'b0);
    pulse_far_end(3'b001);
    wait_state(WAIT_COMINIT);
    repeat ($urandom_range(6, 1)) @(posedge clk);
    pulse_far_end(3'b010);
    wait_state(SEND_COMWAKE);
    check_bit("tx_comm_wake", tx_comm_wake, 1'b1);
    check_bit("tx_comm_reset", tx_comm_reset, 1'b0);
    pulse_far_end(3'b001);
    wait_state(WAIT_COMWAKE);
    repeat ($urandom_range(6, 1)) @(posedge clk);
    pulse_far_end(3'b100);
    wait_state(SEND_D10_2);
    check_bit("tx_elec_idle", tx_elec_idle, 1'b0);
    check_dword("tx_dout", tx_dout, PRIM_D10_2);
    check_bit("tx_is_k", tx_is_k, 1'b0);
    // Device answers with byte-aligned ALIGN
    @(posedge clk);
    rx_din.data        <= PRIM_ALIGN;
    rx_is_k            <= 4'b0001;
    rx_byte_is_aligned <= 1'b1;
    wait_state(SEND_ALIGN);
    check_bit("linkup", linkup, 1'b0);
    @(negedge clk);
    check_state("oob_state", oob_state, LINKED);
    check_bit("linkup", linkup, 1'b1);
  endtask

  task automatic count_align_to_ready(output int n);
    n = 0;
    while (!phy_ready && n < 16) begin
      check_dword("tx_dout", tx_dout, PRIM_ALIGN);
      check_bit("tx_is_k", tx_is_k, 1'b1);
      n++;
      @(negedge clk);
    end
  endtask

  task automatic reset_values();
    start_test("reset");
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_bit("in_ready", in_ready, 1'b0);
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit("linkup", linkup, 1'b0);
    check_bit("phy_ready", phy_ready, 1'b0);
    check_bit("platform_error", platform_error, 1'b0);
    check_bit("tx_comm_reset", tx_comm_reset, 1'b0);
    check_bit("tx_comm_wake", tx_comm_wake, 1'b0);
    check_bit("tx_elec_idle", tx_elec_idle, 1'b1);
    check_state("oob_state", oob_state, RESET_IDLE);
    finish_test();
  endtask

  task automatic link_bring_up();
    int n;
    start_test("bring_up");
    stall_cycles = 0;
    // Words written before linkup fill the FIFO and stall the producer
    fork
      send_words(20);
      begin
        @(posedge clk);
        platform_ready <= 1'b1;
        far_end_bring_up();
        count_align_to_ready(n);
        check_count("ALIGN dwords before phy_ready", n, 3);
      end
    join
    check_bit("in_ready stalled on full FIFO", stall_cycles > 0, 1'b1);
    finish_test();
  endtask

  task automatic payload_stream();
    start_test("data_path");
    send_words(24);
    wait_drain();
    compare_payload();
    @(negedge clk);
    check_bit("phy_ready", phy_ready, 1'b1);
    check_dword("tx_dout", tx_dout, PRIM_SYNC);
    check_bit("tx_is_k", tx_is_k, 1'b1);
    finish_test();
  endtask

  task automatic periodic_align_insertion();
    int n;
    int ready_cycles;
    start_test("periodic_align");
    wait_phy_ready(1'b0);
    count_align_to_ready(n);
    check_count("ALIGN dwords inserted", n, 2);
    fork
      begin
        repeat (`SATA_ALIGN_INTERVAL - 20) @(posedge clk);
        send_words(48);
      end
      begin
        ready_cycles = 0;
        while (phy_ready && ready_cycles < 2 * `SATA_ALIGN_INTERVAL) begin
          ready_cycles++;
          @(negedge clk);
        end
        check_count("READY cycles between ALIGN pairs", ready_cycles, `SATA_ALIGN_INTERVAL);
        count_align_to_ready(n);
        check_count("ALIGN dwords inserted", n, 2);
      end
    join
    wait_drain();
    compare_payload();
    finish_test();
  endtask

  task automatic phy_error_recovery();
    int n;
    start_test("errors");
    wait_phy_ready(1'b1);
    @(posedge clk);
    phy_error <= 1'b1;
    @(posedge clk);
    phy_error <= 1'b0;
    @(negedge clk);
    check_bit("platform_error", platform_error, 1'b1);
    check_bit("linkup", linkup, 1'b0);
    check_state("oob_state", oob_state, RESET_IDLE);
    far_end_bring_up();
    count_align_to_ready(n);
    check_count("ALIGN dwords before phy_ready", n, 3);
    check_bit("phy_ready", phy_ready, 1'b1);
    check_bit("platform_error", platform_error, 1'b0);
    finish_test();
  endtask

  task automatic oob_timeout_retries();
    int cycles;
    start_test("timeout");
    // Far end goes idle and the link drops
    @(posedge clk);
    rx_elec_idle <= 1'b1;
    @(posedge clk);
    rx_elec_idle <= 1'b0;
    @(negedge clk);
    check_bit("linkup", linkup, 1'b0);
    check_state("oob_state", oob_state, RESET_IDLE);
    wait_state(SEND_COMRESET);
    for (int i = 0; i <= `SATA_OOB_MAX_RETRY; i++) begin
      check_bit("tx_comm_reset", tx_comm_reset, 1'b1);
      pulse_far_end(3'b001);
      cycles = 0;
      @(negedge clk);
      while (oob_state == WAIT_COMINIT && cycles < WAIT_LIMIT) begin
        cycles++;
        @(negedge clk);
      end
      check_count("WAIT_COMINIT cycles", cycles, `SATA_OOB_TIMEOUT);
      check_state("oob_state", oob_state,
                  (i < `SATA_OOB_MAX_RETRY) ? SEND_COMRESET : FAILED);
    end
    check_bit("platform_error", platform_error, 1'b1);
    check_bit("linkup", linkup, 1'b0);
    finish_test();
  endtask

  initial begin
    void'($urandom(32'h238ac39a));
    rst                = 1'b1;
    platform_ready     = 1'b0;
    phy_error          = 1'b0;
    tx_oob_complete    = 1'b0;
    rx_din             = '0;
    rx_is_k            = 4'h0;
    rx_elec_idle       = 1'b0;
    rx_byte_is_aligned = 1'b0;
    comm_init_detect   = 1'b0;
    comm_wake_detect   = 1'b0;
    in_data            = '0;
    in_valid           = 1'b0;
    reset_values();
    link_bring_up();
    payload_stream();
    periodic_align_insertion();
    phy_error_recovery();
    oob_timeout_retries();
    $display("Checks: %0d, errors: %0d", checks_run, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog for a stuck run
  initial begin
    repeat (20 * WAIT_LIMIT) @(posedge clk);
    $display("Simulation did not finish in time");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/sata_prim_pkg.sv
verilog/sata_link_pkg.sv
verilog/oob_controller.sv
verilog/tx_dword_fifo.sv
verilog/sata_phy_layer.sv
verilog/sata_phy_top.sv
tests/tb_sata_phy.sv

// ==== verilog/oob_controller.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "sata_defs.svh"

module oob_controller
  import sata_prim_pkg::*, sata_link_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        platform_ready,
  input  wire logic        phy_error,
  input  wire logic        tx_oob_complete,
  input  wire sata_dword_u rx_din,
  input  wire logic [3:0]  rx_is_k,
  input  wire logic        rx_elec_idle,
  input  wire logic        rx_byte_is_aligned,
  input  wire logic        comm_init_detect,
  input  wire logic        comm_wake_detect,
  output logic             platform_error,
  output logic             linkup,
  output sata_dword_u      tx_dout,
  output logic             tx_is_k,
  output logic             tx_comm_reset,
  output logic             tx_comm_wake,
  output logic             tx_set_elec_idle,
  output oob_state_e       state
);

  localparam int TIMER_W = $clog2(`SATA_OOB_TIMEOUT + 1);
  localparam int RETRY_W = $clog2(`SATA_OOB_MAX_RETRY + 1);

  oob_state_e         state_next;
  logic [TIMER_W-1:0] timer;
  logic [RETRY_W-1:0] retry_count;
  logic               waiting;
  logic               timed_out;
  logic               retry_done;
  logic               align_det;

  // Timer only matters while waiting on the far end
  assign waiting    = state inside {WAIT_COMINIT, WAIT_COMWAKE, SEND_D10_2};
  assign timed_out  = waiting && (timer == TIMER_W'(`SATA_OOB_TIMEOUT - 1));
  assign retry_done = (retry_count == RETRY_W'(`SATA_OOB_MAX_RETRY));

  // ALIGN seen on a byte-aligned K dword
  assign align_det = rx_is_k[0] && rx_byte_is_aligned &&
                     (rx_din.prim.b0 == `SATA_K28_5);

  always_comb begin
    state_next = state;
    case (state)
      RESET_IDLE: begin
        if (platform_ready) state_next = SEND_COMRESET;
      end
      SEND_COMRESET: begin
        if (tx_oob_complete) state_next = WAIT_COMINIT;
      end
      WAIT_COMINIT: begin
        if (comm_init_detect) state_next = SEND_COMWAKE;
        else if (timed_out) state_next = retry_done ? FAILED : SEND_COMRESET;
      end
      SEND_COMWAKE: begin
        if (tx_oob_complete) state_next = WAIT_COMWAKE;
      end
      WAIT_COMWAKE: begin
        if (comm_wake_detect) state_next = SEND_D10_2;
        else if (timed_out) state_next = retry_done ? FAILED : SEND_COMRESET;
      end
      SEND_D10_2: begin
        if (align_det) state_next = SEND_ALIGN;
        else if (timed_out) state_next = retry_done ? FAILED : SEND_COMRESET;
      end
      SEND_ALIGN: begin
        state_next = LINKED;
      end
      LINKED: begin
        // Far end went idle or the phy layer gave up
        if (rx_elec_idle || phy_error) state_next = RESET_IDLE;
      end
      FAILED: begin
        if (!platform_ready) state_next = RESET_IDLE;
      end
      default: begin
        state_next = RESET_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= RESET_IDLE;
      timer       <= '0;
      retry_count <= '0;
    end else begin
      state <= state_next;
      if (state_next != state) begin
        timer <= '0;
      end else begin
        timer <= timer + 1'b1;
      end
      if (state == RESET_IDLE || state == LINKED) begin
        retry_count <= '0;
      end else if (timed_out && !retry_done) begin
        retry_count <= retry_count + 1'b1;
      end
    end
  end

  // Outputs decoded from the state
  assign tx_comm_reset    = (state == SEND_COMRESET);
  assign tx_comm_wake     = (state == SEND_COMWAKE);
  assign tx_set_elec_idle = !(state inside {SEND_D10_2, SEND_ALIGN, LINKED});
  assign linkup           = (state == LINKED);
  assign platform_error   = (state == FAILED);

  always_comb begin
    tx_dout.data = `SATA_PRIM_D10_2;
    tx_is_k      = 1'b0;
    if (state == SEND_ALIGN || state == LINKED) begin
      tx_dout.data = `SATA_PRIM_ALIGN;
      tx_is_k      = 1'b1;
    end
  end

  // COMWAKE only goes out once COMINIT was seen
  a_comwake_after_cominit : assert property (
    @(posedge clk) disable iff (rst) $rose(tx_comm_wake) |-> $past(comm_init_detect)
  );

  // Linkup only ever follows an ALIGN being sent
  a_linkup_state : assert property (
    @(posedge clk) disable iff (rst)
    linkup |-> (state == LINKED) && ($past(state) inside {SEND_ALIGN, LINKED})
  );

endmodule

`default_nettype wire

// ==== verilog/sata_defs.svh ====
`ifndef SATA_DEFS_SVH
`define SATA_DEFS_SVH

// Primitive dwords, byte 0 is the first byte on the wire
`define SATA_PRIM_ALIGN     32'h7B4A4ABC
`define SATA_PRIM_SYNC      32'hB5B5957C
`define SATA_PRIM_D10_2     32'h4A4A4A4A

// K28.5 control character, found in byte 0 of ALIGN
`define SATA_K28_5          8'hBC

// READY cycles between two ALIGN pairs
`define SATA_ALIGN_INTERVAL 256

// Cycles without a far-end answer before COMRESET is sent again
`define SATA_OOB_TIMEOUT    2048

// Retries allowed before the platform error is raised
`define SATA_OOB_MAX_RETRY  3

// Transmit buffer depth in dwords
`define SATA_TX_FIFO_DEPTH  16

`endif

// ==== verilog/sata_link_pkg.sv ====
`default_nettype none

package sata_link_pkg;

  // Out-of-band bring-up states, also exported for debug
  typedef enum logic [3:0] {
    RESET_IDLE    = 4'h0,
    SEND_COMRESET = 4'h1,
    WAIT_COMINIT  = 4'h2,
    SEND_COMWAKE  = 4'h3,
    WAIT_COMWAKE  = 4'h4,
    SEND_D10_2    = 4'h5,
    SEND_ALIGN    = 4'h6,
    LINKED        = 4'h7,
    FAILED        = 4'h8
  } oob_state_e;

  // Phy layer states after linkup
  typedef enum logic [1:0] {
    NOT_READY         = 2'h0,
    SEND_FIRST_ALIGN  = 2'h1,
    SEND_SECOND_ALIGN = 2'h2,
    READY             = 2'h3
  } phy_state_e;

endpackage

`default_nettype wire

// ==== verilog/sata_phy_layer.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "sata_defs.svh"

module sata_phy_layer
  import sata_prim_pkg::*, sata_link_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        linkup,
  input  wire logic        phy_error,
  input  wire logic        oob_platform_error,
  input  wire sata_dword_u oob_tx_dout,
  input  wire logic        oob_tx_is_k,
  input  wire sata_dword_u fifo_data,
  input  wire logic        fifo_valid,
  output logic             fifo_ready,
  output sata_dword_u      tx_dout,
  output logic             tx_is_k,
  output logic             phy_ready,
  output logic             platform_error
);

  localparam int ALIGN_W = $clog2(`SATA_ALIGN_INTERVAL);

  phy_state_e         state;
  logic [ALIGN_W-1:0] align_count;
  logic               phy_platform_error;

  always_ff @(posedge clk) begin
    if (rst) begin
      state              <= NOT_READY;
      align_count        <= '0;
      phy_platform_error <= 1'b0;
    end else if (!linkup) begin
      // Lost link, keep the error until the next bring-up
      state       <= NOT_READY;
      align_count <= '0;
    end else begin
      case (state)
        NOT_READY: begin
          align_count        <= '0;
          phy_platform_error <= 1'b0;
          state              <= SEND_FIRST_ALIGN;
        end
        SEND_FIRST_ALIGN: begin
          state <= SEND_SECOND_ALIGN;
        end
        SEND_SECOND_ALIGN: begin
          state <= READY;
        end
        READY: begin
          align_count <= align_count + 1'b1;
          if (align_count == ALIGN_W'(`SATA_ALIGN_INTERVAL - 1)) state <= SEND_FIRST_ALIGN;
          if (phy_error) phy_platform_error <= 1'b1;
        end
        default: begin
          state <= NOT_READY;
        end
      endcase
    end
  end

  assign phy_ready      = (state == READY);
  assign fifo_ready     = linkup && (state == READY);
  assign platform_error = oob_platform_error || phy_platform_error;

  // OOB words before linkup, then ALIGN, payload or SYNC
  always_comb begin
    if (!linkup) begin
      tx_dout = oob_tx_dout;
      tx_is_k = oob_tx_is_k;
    end else if (state == READY && fifo_valid) begin
      tx_dout = fifo_data;
      tx_is_k = 1'b0;
    end else if (state == READY) begin
      tx_dout.data = `SATA_PRIM_SYNC;
      tx_is_k      = 1'b1;
    end else begin
      tx_dout.data = `SATA_PRIM_ALIGN;
      tx_is_k      = 1'b1;
    end
  end

  // Payload is only taken once the ALIGN pair has gone out
  a_ready_only : assert property (
    @(posedge clk) disable iff (rst)
    fifo_ready |-> (state == READY) && ($past(state) inside {SEND_SECOND_ALIGN, READY})
  );

endmodule

`default_nettype wire

// ==== verilog/sata_phy_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module sata_phy_top
  import sata_prim_pkg::*, sata_link_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  // Platform status
  input  wire logic        platform_ready,
  input  wire logic        phy_error,
  output logic             platform_error,
  output logic             linkup,
  output logic             phy_ready,
  output oob_state_e       oob_state,
  // Transceiver
  output sata_dword_u      tx_dout,
  output logic             tx_is_k,
  output logic             tx_comm_reset,
  output logic             tx_comm_wake,
  output logic             tx_elec_idle,
  input  wire logic        tx_oob_complete,
  input  wire sata_dword_u rx_din,
  input  wire logic [3:0]  rx_is_k,
  input  wire logic        rx_elec_idle,
  input  wire logic        rx_byte_is_aligned,
  input  wire logic        comm_init_detect,
  input  wire logic        comm_wake_detect,
  // Producer side of the transmit buffer
  input  wire sata_dword_u in_data,
  input  wire logic        in_valid,
  output logic             in_ready
);

  sata_dword_u oob_tx_dout;
  logic        oob_tx_is_k;
  logic        oob_platform_error;
  sata_dword_u fifo_data;
  logic        fifo_valid;
  logic        fifo_ready;

  oob_controller oob (
    .clk                (clk),
    .rst                (rst),
    .platform_ready     (platform_ready),
    .phy_error          (phy_error),
    .tx_oob_complete    (tx_oob_complete),
    .rx_din             (rx_din),
    .rx_is_k            (rx_is_k),
    .rx_elec_idle       (rx_elec_idle),
    .rx_byte_is_aligned (rx_byte_is_aligned),
    .comm_init_detect   (comm_init_detect),
    .comm_wake_detect   (comm_wake_detect),
    .platform_error     (oob_platform_error),
    .linkup             (linkup),
    .tx_dout            (oob_tx_dout),
    .tx_is_k            (oob_tx_is_k),
    .tx_comm_reset      (tx_comm_reset),
    .tx_comm_wake       (tx_comm_wake),
    .tx_set_elec_idle   (tx_elec_idle),
    .state              (oob_state)
  );

  tx_dword_fifo fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (fifo_data),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  sata_phy_layer phy (
    .clk                (clk),
    .rst                (rst),
    .linkup             (linkup),
    .phy_error          (phy_error),
    .oob_platform_error (oob_platform_error),
    .oob_tx_dout        (oob_tx_dout),
    .oob_tx_is_k        (oob_tx_is_k),
    .fifo_data          (fifo_data),
    .fifo_valid         (fifo_valid),
    .fifo_ready         (fifo_ready),
    .tx_dout            (tx_dout),
    .tx_is_k            (tx_is_k),
    .phy_ready          (phy_ready),
    .platform_error     (platform_error)
  );

endmodule

`default_nettype wire

// ==== verilog/sata_prim_pkg.sv ====
`default_nettype none

package sata_prim_pkg;

  // One byte of a dword on the link
  typedef logic [7:0] sata_prim_byte_t;

  // Byte view of a dword, b0 goes out first
  typedef struct packed {
    sata_prim_byte_t b3;
    sata_prim_byte_t b2;
    sata_prim_byte_t b1;
    sata_prim_byte_t b0;
  } sata_prim_s;

  // A transmit or receive dword
  // Payload logic reads it as data, primitive detection as bytes
  typedef union packed {
    logic [31:0] data;
    sata_prim_s  prim;
  } sata_dword_u;

endpackage

`default_nettype wire

// ==== verilog/tx_dword_fifo.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "sata_defs.svh"

module tx_dword_fifo
  import sata_prim_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire sata_dword_u in_data,
  input  wire logic        in_valid,
  output logic             in_ready,
  output sata_dword_u      out_data,
  output logic             out_valid,
  input  wire logic        out_ready
);

  localparam int DEPTH   = `SATA_TX_FIFO_DEPTH;
  localparam int PTR_W   = $clog2(DEPTH);
  localparam int COUNT_W = $clog2(DEPTH + 1);

  sata_dword_u        mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [COUNT_W-1:0] count;
  logic [COUNT_W-1:0] count_next;
  logic               push;
  logic               pop;

  assign push     = in_valid && in_ready;
  assign pop      = out_valid && out_ready;
  assign out_data = mem[rd_ptr];

  always_comb begin
    case ({push, pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_ready  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count_next;
      // Flags follow the count of the next cycle
      in_ready  <= (count_next != COUNT_W'(DEPTH));
      out_valid <= (count_next != '0);
    end
  end

  a_no_push_full : assert property (
    @(posedge clk) disable iff (rst) push |-> count < COUNT_W'(DEPTH)
  );

  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (rst) pop |-> count != '0
  );

endmodule

`default_nettype wire
